// File: uart_pkg.sv
package uart_pkg;

    // Serial character width, LSB goes out first
    localparam int BYTE_BITS = 8;

    // One character as seen by the receiver
    // frame_err is set when the stop bit sampled low
    typedef struct packed {
        logic                 frame_err; // Stop bit was low
        logic [BYTE_BITS-1:0] data;      // Payload byte
    } rx_byte_t;

endpackage

// File: reg_pkg.sv
package reg_pkg;

    // Command kinds carried in the top two frame bits
    // Kind 2'b00 is left unassigned and gets rejected
    localparam logic [1:0] CMD_WRITE    = 2'b01;
    localparam logic [1:0] CMD_READ     = 2'b10;
    localparam logic [1:0] CMD_READ_CNT = 2'b11;

    // First byte of every response
    localparam logic [7:0] RESP_ACK  = 8'hA5; // Write done
    localparam logic [7:0] RESP_DATA = 8'h5A; // Read words follow
    localparam logic [7:0] RESP_ERR  = 8'hEE; // Command rejected

    // Write frame layout
    typedef struct packed {
        logic [1:0]  kind;
        logic [5:0]  index; // Target register
        logic [15:0] data;  // New register value
    } wr_view_t;

    // Read frame layout
    typedef struct packed {
        logic [1:0]  kind;
        logic [5:0]  index; // First register of the run
        logic [3:0]  len;   // Words to return
        logic [11:0] rsvd;
    } rd_view_t;

    // Three frame bytes in arrival order, first byte on top
    typedef union packed {
        wr_view_t wr_view;
        rd_view_t rd_view;
    } cmd_frame_u;

    // Broadcast to every register slot
    typedef struct packed {
        logic        wr;      // Single-cycle write strobe
        logic [5:0]  index;   // Slot select
        logic [15:0] wdata;
        logic        cnt_sel; // Read back write count instead of value
    } slot_req_t;

    // Zero unless the slot is selected
    typedef struct packed {
        logic [15:0] word;
    } slot_rd_t;

endpackage

// File: uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    output logic               rx_valid,
    output uart_pkg::rx_byte_t rx_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W = $clog2(uart_pkg::BYTE_BITS);
    localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 - 1 : 0;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]                     rx_sync;  // [1] is the usable copy
    logic [1:0]                     state;
    logic [CNT_W-1:0]               clk_cnt;
    logic [IDX_W-1:0]               bit_idx;
    logic [uart_pkg::BYTE_BITS-1:0] shift;
    logic                           tick;     // Middle of a data or stop bit

    assign tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync <= 2'b11; // Idle line is high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0; // Strobe by default
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync[1]) begin
                        state <= S_START; // Falling edge seen
                    end
                end
                S_START: begin
                    if (clk_cnt == CNT_W'(HALF)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync[1] ? S_IDLE : S_DATA; // Reject short glitches
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(uart_pkg::BYTE_BITS - 1)) begin
                            state <= S_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (tick) begin
                        rx_valid <= 1'b1; // Byte out one cycle after stop sample
                        state    <= S_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == S_DATA && tick) begin
            shift <= {rx_sync[1], shift[uart_pkg::BYTE_BITS-1:1]}; // LSB arrives first
        end
        if (state == S_STOP && tick) begin
            rx_byte.data      <= shift;
            rx_byte.frame_err <= !rx_sync[1]; // Stop bit must be high
        end
    end

    // Engine has no back-pressure, each byte must be a lone pulse
    assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else $error("uart_rx: rx_valid held for two cycles");

endmodule

// File: uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tx_start,
    input  logic [uart_pkg::BYTE_BITS-1:0] tx_data,
    input  logic                           cts_n,
    output logic                           tx,
    output logic                           tx_busy
);

    localparam int FRAME_BITS = uart_pkg::BYTE_BITS + 2; // Start, data, stop
    localparam int CNT_W      = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W      = $clog2(FRAME_BITS);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HOLD = 2'd1;
    localparam logic [1:0] S_SEND = 2'd2;

    logic [1:0]            state;
    logic [1:0]            cts_sync;  // Host-side signal, resync
    logic [CNT_W-1:0]      clk_cnt;
    logic [IDX_W-1:0]      bit_idx;
    logic [FRAME_BITS-1:0] shift;
    logic                  tick;

    assign tick    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign tx      = (state == S_SEND) ? shift[0] : 1'b1; // Idle high outside a frame
    assign tx_busy = (state != S_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            cts_sync <= 2'b11;
            clk_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            cts_sync <= {cts_sync[0], cts_n};
            case (state)
                S_IDLE: begin
                    if (tx_start) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!cts_sync[1]) begin
                        state <= S_SEND; // Host ready, start bit next
                    end
                end
                default: begin
                    if (tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                            state <= S_IDLE; // Stop bit done
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_start) begin
            shift <= {1'b1, tx_data, 1'b0};
        end else if (state == S_SEND && tick) begin
            shift <= {1'b1, shift[FRAME_BITS-1:1]};
        end
    end

    // Engine must pace itself on tx_busy
    assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while busy");

endmodule

// File: cmd_engine.sv
`timescale 1ns/10ps

module cmd_engine #(
    parameter int NUM_REGS = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  uart_pkg::rx_byte_t rx_byte,
    output reg_pkg::slot_req_t req,
    input  reg_pkg::slot_rd_t  rd_word,
    output logic               tx_start,
    output logic [7:0]         tx_data,
    input  logic               tx_busy,
    output logic               rts_n
);

    localparam logic [2:0] S_IDLE   = 3'd0; // Collecting frame bytes
    localparam logic [2:0] S_DECODE = 3'd1;
    localparam logic [2:0] S_TX     = 3'd2; // Waiting to hand a byte over
    localparam logic [2:0] S_TXWAIT = 3'd3; // Byte on the wire
    localparam logic [2:0] S_FETCH  = 3'd4; // Collector latches the word
    localparam logic [2:0] S_LOAD   = 3'd5;

    logic [2:0]          state;
    logic [1:0]          byte_cnt;
    reg_pkg::cmd_frame_u frame;
    logic [5:0]          rd_ptr;
    logic [3:0]          words_left;
    logic                lo_pending; // Low byte of current word still to send
    logic [7:0]          lo_byte;
    logic [1:0]          kind;
    logic                is_read;
    logic                bad_cmd;
    logic [6:0]          run_end;

    assign kind     = frame.rd_view.kind; // Same bits in both views
    assign is_read  = (kind == reg_pkg::CMD_READ) || (kind == reg_pkg::CMD_READ_CNT);
    assign run_end  = {1'b0, frame.rd_view.index} + 7'(frame.rd_view.len);
    assign tx_start = (state == S_TX) && !tx_busy;

    always_comb begin
        bad_cmd = 1'b0;
        if (kind != reg_pkg::CMD_WRITE && !is_read) begin
            bad_cmd = 1'b1; // Kind 00
        end
        if ({1'b0, frame.wr_view.index} >= 7'(NUM_REGS)) begin
            bad_cmd = 1'b1;
        end
        if (is_read && (frame.rd_view.len == 4'd0 || run_end > 7'(NUM_REGS))) begin
            bad_cmd = 1'b1; // Empty or overrunning burst
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            byte_cnt   <= '0;
            rts_n      <= 1'b1;
            req        <= '0;
            rd_ptr     <= '0;
            words_left <= '0;
            lo_pending <= 1'b0;
        end else begin
            req.wr <= 1'b0;
            case (state)
                S_IDLE: begin
                    rts_n <= 1'b0; // Ready for the host
                    if (rx_valid) begin
                        if (rx_byte.frame_err) begin
                            byte_cnt <= '0; // Drop partial frame, no reply
                        end else if (byte_cnt == 2'd2) begin
                            byte_cnt <= '0;
                            rts_n    <= 1'b1; // Hold host off until reply done
                            state    <= S_DECODE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_DECODE: begin
                    rd_ptr     <= frame.rd_view.index;
                    words_left <= '0;
                    lo_pending <= 1'b0;
                    state      <= S_TX;
                    if (!bad_cmd && !is_read) begin
                        req.wr    <= 1'b1;
                        req.index <= frame.wr_view.index;
                        req.wdata <= frame.wr_view.data;
                    end else if (!bad_cmd) begin
                        words_left  <= frame.rd_view.len;
                        req.cnt_sel <= (kind == reg_pkg::CMD_READ_CNT);
                    end
                end
                S_TX: begin
                    if (!tx_busy) begin
                        state <= S_TXWAIT;
                    end
                end
                S_TXWAIT: begin
                    if (!tx_busy) begin
                        if (lo_pending) begin
                            lo_pending <= 1'b0;
                            state      <= S_TX;
                        end else if (words_left != 4'd0) begin
                            req.index  <= rd_ptr; // Select next word
                            rd_ptr     <= rd_ptr + 1'b1;
                            words_left <= words_left - 1'b1;
                            state      <= S_FETCH;
                        end else begin
                            rts_n <= 1'b0; // Last stop bit sent
                            state <= S_IDLE;
                        end
                    end
                end
                S_FETCH: state <= S_LOAD;
                S_LOAD: begin
                    lo_pending <= 1'b1;
                    state      <= S_TX;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Frame and response bytes
    always_ff @(posedge clk) begin
        if (state == S_IDLE && rx_valid && !rx_byte.frame_err) begin
            frame <= reg_pkg::cmd_frame_u'({frame[15:0], rx_byte.data}); // First byte ends on top
        end
        if (state == S_DECODE) begin
            tx_data <= bad_cmd ? reg_pkg::RESP_ERR :
                       (is_read ? reg_pkg::RESP_DATA : reg_pkg::RESP_ACK);
        end
        if (state == S_TXWAIT && !tx_busy && lo_pending) begin
            tx_data <= lo_byte;
        end
        if (state == S_LOAD) begin
            tx_data <= rd_word.word[15:8]; // High byte first
            lo_byte <= rd_word.word[7:0];
        end
    end

    // Slots past NUM_REGS do not exist
    assert property (@(posedge clk) disable iff (rst) req.wr |-> ({1'b0, req.index} < 7'(NUM_REGS)))
        else $error("cmd_engine: write strobe to index %0d", req.index);

endmodule

// File: reg_slot.sv
`timescale 1ns/10ps

module reg_slot #(
    parameter int SLOT_INDEX = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  reg_pkg::slot_req_t req,
    output logic [15:0]        value,
    output reg_pkg::slot_rd_t  rd
);

    logic       hit;    // Request addresses this slot
    logic [7:0] wr_cnt;

    assign hit = (req.index == 6'(SLOT_INDEX));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value  <= '0;
            wr_cnt <= '0;
        end else if (req.wr && hit) begin
            value <= req.wdata; // Shows on regs_out next cycle
            if (wr_cnt != 8'hFF) begin
                wr_cnt <= wr_cnt + 1'b1; // Saturates at 255
            end
        end
    end

    // Unselected slots stay quiet for the OR in the collector
    always_comb begin
        rd.word = '0;
        if (hit) begin
            rd.word = req.cnt_sel ? {8'h00, wr_cnt} : value;
        end
    end

endmodule

// File: readback_collect.sv
`timescale 1ns/10ps

module readback_collect #(
    parameter int NUM_REGS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  reg_pkg::slot_rd_t slot_rd [NUM_REGS],
    output reg_pkg::slot_rd_t rd_word
);

    localparam int CNT_W = $clog2(NUM_REGS + 1);

    logic [15:0]      or_word;
    logic [CNT_W-1:0] nz_cnt;  // Slots driving a nonzero word

    always_comb begin
        or_word = '0;
        nz_cnt  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            or_word = or_word | slot_rd[i].word;
            if (slot_rd[i].word != 16'h0000) begin
                nz_cnt = nz_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_word <= '0;
        end else begin
            rd_word.word <= or_word; // Valid one cycle after req moves
        end
    end

    // Slot index decode must be one-hot across the generate loop
    assert property (@(posedge clk) disable iff (rst) nz_cnt <= CNT_W'(1))
        else $error("readback_collect: %0d slots driving readback", nz_cnt);

endmodule

// File: uart_reg_bridge_top.sv
`timescale 1ns/10ps

module uart_reg_bridge_top #(
    parameter int CLKS_PER_BIT = 8,
    parameter int NUM_REGS     = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       uart_rx,
    output logic                       uart_tx,
    output logic                       uart_rts_n,
    input  logic                       uart_cts_n,
    output logic [NUM_REGS-1:0][15:0]  regs_out   // Control outputs, one word per slot
);

    logic               rx_valid;
    uart_pkg::rx_byte_t rx_byte;
    reg_pkg::slot_req_t req;
    reg_pkg::slot_rd_t  slot_rd [NUM_REGS];
    reg_pkg::slot_rd_t  rd_word;
    logic               tx_start;
    logic [7:0]         tx_data;
    logic               tx_busy;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    cmd_engine #(
        .NUM_REGS(NUM_REGS)
    ) u_engine (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .req      (req),
        .rd_word  (rd_word),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .rts_n    (uart_rts_n)
    );

    // One slot per register, same request to all
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_slot
        reg_slot #(
            .SLOT_INDEX(i)
        ) u_slot (
            .clk   (clk),
            .rst   (rst),
            .req   (req),
            .value (regs_out[i]),
            .rd    (slot_rd[i])
        );
    end

    readback_collect #(
        .NUM_REGS(NUM_REGS)
    ) u_collect (
        .clk     (clk),
        .rst     (rst),
        .slot_rd (slot_rd),
        .rd_word (rd_word)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .cts_n    (uart_cts_n),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: tb_uart_reg_bridge.sv
`timescale 1ns/10ps

module tb_uart_reg_bridge;

    localparam int CLKS_PER_BIT  = 8;
    localparam int NUM_REGS      = 8;
    localparam int MAX_ROWS      = 40;
    localparam int START_TIMEOUT = 40 * CLKS_PER_BIT; // Covers a full frame plus decode
    localparam int SEED          = 32'he802;

    logic                      clk;
    logic                      rst;
    logic                      uart_rx;
    logic                      uart_tx;
    logic                      uart_rts_n;
    logic                      uart_cts_n;
    logic [NUM_REGS-1:0][15:0] regs_out;

    // Command table
    string       row_name [MAX_ROWS];
    logic [7:0]  row_hdr  [MAX_ROWS]; // Expected first response byte
    logic [23:0] row_frame[MAX_ROWS];
    bit          row_rand [MAX_ROWS]; // Low 16 bits from $urandom
    bit          row_cts  [MAX_ROWS]; // Hold cts_n high before the reply
    int          num_rows;

    // Host-side view of the bridge
    logic [15:0] model_val[NUM_REGS];
    logic [7:0]  model_cnt[NUM_REGS];
    logic [7:0]  exp_q[$];
    logic [7:0]  rx_q[$];

    string cur_name;
    int    check_count;
    int    err_count;
    bit    timed_out;

    uart_reg_bridge_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .NUM_REGS    (NUM_REGS)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .uart_rx    (uart_rx),
        .uart_tx    (uart_tx),
        .uart_rts_n (uart_rts_n),
        .uart_cts_n (uart_cts_n),
        .regs_out   (regs_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [23:0] wr_frame(input int idx, input logic [15:0] data);
        return {reg_pkg::CMD_WRITE, 6'(idx), data};
    endfunction

    function automatic logic [23:0] rd_frame(input logic [1:0] kind, input int idx,
                                             input int len);
        return {kind, 6'(idx), 4'(len), 12'h000}; // Reserved bits zero
    endfunction

    task automatic add_row(input string name, input logic [7:0] hdr, input logic [23:0] frame,
                           input bit rnd, input bit cts);
        row_name[num_rows]  = name;
        row_hdr[num_rows]   = hdr;
        row_frame[num_rows] = frame;
        row_rand[num_rows]  = rnd;
        row_cts[num_rows]   = cts;
        num_rows++;
    endtask

    task automatic build_table();
        num_rows = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            add_row($sformatf("wr_%0d", i), reg_pkg::RESP_ACK, wr_frame(i, 16'h0000), 1'b1, 1'b0);
            add_row($sformatf("rd_%0d", i), reg_pkg::RESP_DATA,
                    rd_frame(reg_pkg::CMD_READ, i, 1), 1'b0, 1'b0);
        end
        // Extra writes so the counters differ
        add_row("wr_3_again", reg_pkg::RESP_ACK, wr_frame(3, 16'h0000), 1'b1, 1'b0);
        add_row("wr_5_again", reg_pkg::RESP_ACK, wr_frame(5, 16'h0000), 1'b1, 1'b0);
        add_row("wr_3_third", reg_pkg::RESP_ACK, wr_frame(3, 16'h0000), 1'b1, 1'b0);
        add_row("burst_2_5", reg_pkg::RESP_DATA, rd_frame(reg_pkg::CMD_READ, 2, 5), 1'b0, 1'b0);
        add_row("burst_all", reg_pkg::RESP_DATA, rd_frame(reg_pkg::CMD_READ, 0, 8), 1'b0, 1'b0);
        add_row("cnt_all", reg_pkg::RESP_DATA,
                rd_frame(reg_pkg::CMD_READ_CNT, 0, 8), 1'b0, 1'b0);
        add_row("cnt_3_2", reg_pkg::RESP_DATA,
                rd_frame(reg_pkg::CMD_READ_CNT, 3, 2), 1'b0, 1'b0);
        // Rejected commands
        add_row("err_kind0", reg_pkg::RESP_ERR, 24'h03_1234, 1'b0, 1'b0);
        add_row("err_wr_idx", reg_pkg::RESP_ERR, wr_frame(8, 16'hBEEF), 1'b0, 1'b0);
        add_row("err_rd_idx", reg_pkg::RESP_ERR, rd_frame(reg_pkg::CMD_READ, 9, 1), 1'b0, 1'b0);
        add_row("err_len0", reg_pkg::RESP_ERR, rd_frame(reg_pkg::CMD_READ, 1, 0), 1'b0, 1'b0);
        add_row("err_overrun", reg_pkg::RESP_ERR,
                rd_frame(reg_pkg::CMD_READ, 6, 3), 1'b0, 1'b0);
        add_row("err_cnt_over", reg_pkg::RESP_ERR,
                rd_frame(reg_pkg::CMD_READ_CNT, 7, 2), 1'b0, 1'b0);
        add_row("after_err", reg_pkg::RESP_DATA, rd_frame(reg_pkg::CMD_READ, 0, 8), 1'b0, 1'b0);
        // Flow control
        add_row("cts_write", reg_pkg::RESP_ACK, wr_frame(6, 16'h0000), 1'b1, 1'b1);
        add_row("cts_burst", reg_pkg::RESP_DATA, rd_frame(reg_pkg::CMD_READ, 4, 4), 1'b0, 1'b1);
    endtask

    // Applies the command rules, fills exp_q, updates the model
    task automatic model_command(input logic [23:0] frame);
        logic [1:0]  kind;
        logic [5:0]  idx;
        logic [3:0]  len;
        logic [15:0] w;
        int          last;
        kind = frame[23:22];
        idx  = frame[21:16];
        len  = frame[15:12];
        last = int'(idx) + int'(len); // One past the last word
        exp_q.delete();
        if (kind == 2'b00 || int'(idx) >= NUM_REGS ||
            (kind != reg_pkg::CMD_WRITE && (len == 4'd0 || last > NUM_REGS))) begin
            exp_q.push_back(reg_pkg::RESP_ERR);
        end else if (kind == reg_pkg::CMD_WRITE) begin
            model_val[int'(idx)] = frame[15:0];
            if (model_cnt[int'(idx)] != 8'hFF) begin
                model_cnt[int'(idx)] = model_cnt[int'(idx)] + 8'd1; // Saturating
            end
            exp_q.push_back(reg_pkg::RESP_ACK);
        end else begin
            exp_q.push_back(reg_pkg::RESP_DATA);
            for (int j = int'(idx); j < last; j++) begin
                w = (kind == reg_pkg::CMD_READ_CNT) ? {8'h00, model_cnt[j]} : model_val[j];
                exp_q.push_back(w[15:8]); // High byte first
                exp_q.push_back(w[7:0]);
            end
        end
    endtask

    // Called on a falling edge, leaves on one
    task automatic drive_bit(input logic value);
        uart_rx = value;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        @(negedge clk);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]); // LSB first
        end
        drive_bit(1'b1);
    endtask

    task automatic send_frame(input logic [23:0] frame);
        send_byte(frame[23:16]);
        send_byte(frame[15:8]);
        send_byte(frame[7:0]);
    endtask

    // Returns in the middle of the stop bit
    task automatic receive_byte(output logic [7:0] data);
        int waited;
        data   = '0;
        waited = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0) begin
            if (waited == START_TIMEOUT) begin
                $display("Timeout: no start bit on uart_tx after %0d cycles in %s",
                         waited, cur_name);
                err_count++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(negedge clk);
        end
        check_value({cur_name, " rts_n during reply"}, 16'd1, 16'(uart_rts_n));
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
            err_count++;
            $display("Start bit on uart_tx ended early in %s", cur_name);
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) begin
            err_count++;
            $display("Stop bit on uart_tx was low in %s", cur_name);
        end
    endtask

    task automatic receive_bytes(input int count);
        logic [7:0] data;
        for (int k = 0; k < count && !timed_out; k++) begin
            receive_byte(data);
            if (!timed_out) begin
                rx_q.push_back(data);
            end
        end
    endtask

    task automatic wait_rts_low(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (uart_rts_n !== 1'b0) begin
            if (waited == limit) begin
                $display("Timeout: uart_rts_n still high after %0d cycles in %s",
                         limit, cur_name);
                err_count++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            check_value($sformatf("%s regs_out[%0d]", cur_name, i), model_val[i], regs_out[i]);
        end
    endtask

    task automatic run_row(input int r);
        logic [23:0] frame;
        int          errs_before;
        bit          saw_start;
        cur_name    = row_name[r];
        errs_before = err_count;
        frame       = row_frame[r];
        if (row_rand[r]) begin
            frame = {frame[23:16], 16'($urandom)};
        end
        model_command(frame);
        rx_q.delete();
        if (row_cts[r]) begin
            uart_cts_n = 1'b1; // Host not ready for the reply
            send_frame(frame);
            saw_start = 1'b0;
            repeat (30 * CLKS_PER_BIT) begin
                @(negedge clk);
                if (uart_tx === 1'b0) begin
                    saw_start = 1'b1;
                end
            end
            check_value({cur_name, " tx held by cts_n"}, 16'd1, 16'(!saw_start));
            check_value({cur_name, " rts_n while held"}, 16'd1, 16'(uart_rts_n));
            uart_cts_n = 1'b0;
            receive_bytes(exp_q.size());
        end else begin
            fork
                send_frame(frame);
                receive_bytes(exp_q.size());
            join
        end
        if (timed_out) begin
            $display("%-14s aborted", cur_name);
            return;
        end
        check_value({cur_name, " header"}, 16'(row_hdr[r]), 16'(rx_q[0]));
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value($sformatf("%s byte %0d", cur_name, i), 16'(exp_q[i]), 16'(rx_q[i]));
        end
        wait_rts_low(2 * CLKS_PER_BIT); // Extra reply bytes would keep rts_n high
        check_regs();
        $display("%-14s %0d bytes, %0d errors", cur_name, rx_q.size(), err_count - errs_before);
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        uart_rx     = 1'b1; // Idle line
        uart_cts_n  = 1'b0;
        check_count = 0;
        err_count   = 0;
        timed_out   = 1'b0;
        cur_name    = "reset";
        for (int i = 0; i < NUM_REGS; i++) begin
            model_val[i] = '0;
            model_cnt[i] = '0;
        end
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        wait_rts_low(4 * CLKS_PER_BIT);
        for (int r = 0; r < num_rows && !timed_out; r++) begin
            run_row(r);
        end
        $display("tests=%0d checks=%0d errors=%0d", num_rows, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
uart_pkg.sv
reg_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_engine.sv
reg_slot.sv
readback_collect.sv
uart_reg_bridge_top.sv
tb_uart_reg_bridge.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_uart_reg_bridge \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log
